/* hdl/procPkg.sv */
package procPkg;

	// datapath sizes
	localparam int dataWidth = 16;
	localparam int regSelWidth = 3;
	localparam int regCount = 1 << regSelWidth;

	// instruction ROM
	localparam int romDepth = 16;
	localparam int romAddrWidth = $clog2(romDepth);

	// instruction fields
	localparam int opWidth = 5;
	localparam int opMsb = 15;
	localparam int opLsb = 11;
	localparam int rsMsb = 10;
	localparam int rsLsb = 8;
	localparam int rtMsb = 7;
	localparam int rtLsb = 5;
	localparam int rdMsb = 4;
	localparam int rdLsb = 2;
	localparam int immMsb = 4;
	localparam int immLsb = 0;
	localparam int offMsb = 7;
	localparam int offLsb = 0;

	// unlisted patterns decode as NOP
	typedef enum logic [opWidth-1:0] {
		opHalt = 5'b00000,
		opNop  = 5'b00001,
		opAddi = 5'b01000,
		opBeqz = 5'b01100,
		opSt   = 5'b10000,
		opLd   = 5'b10001,
		opAdd  = 5'b11000,
		opSub  = 5'b11001,
		opAnd  = 5'b11010,
		opXor  = 5'b11011
	} opcode_t;

	typedef enum logic [1:0] {aluAdd, aluSub, aluAnd, aluXor} aluOp_t;

	// bus master states
	typedef enum logic {memIdle, memAccess} memState_t;

	localparam logic [dataWidth-1:0] nopInstr = {opNop, {(dataWidth-opWidth){1'b0}}};

endpackage

/* hdl/fetch.sv */
`timescale 1ns/1ps

module fetch
	import procPkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 stall,
	input  logic                 busStall,
	input  logic                 halt,
	input  logic                 branchTaken,
	input  logic [dataWidth-1:0] branchTarget,
	output logic [dataWidth-1:0] instruction,
	output logic [dataWidth-1:0] pcNext
);

	logic [dataWidth-1:0] rom [romDepth];
	logic [dataWidth-1:0] pc;
	logic [dataWidth-1:0] pcPlusOne;
	logic                 stopped;
	logic                 advance;

	initial begin
		$readmemh("program.hex", rom);
	end

	assign pcPlusOne = pc + 1'b1;
	assign advance = ~stall & ~busStall;

	// sticky once HALT has left decode
	always_ff @(posedge clk) begin
		if (rst) begin
			stopped <= 1'b0;
		end else if (halt & ~busStall) begin
			stopped <= 1'b1;
		end
	end

	// PC and IF/ID register
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			instruction <= nopInstr;
		end else if (advance) begin
			if (branchTaken) begin
				pc <= branchTarget;
				// drop the wrong-path fetch
				instruction <= nopInstr;
			end else if (halt | stopped) begin
				instruction <= nopInstr;
			end else begin
				pc <= pcPlusOne;
				instruction <= rom[pc[romAddrWidth-1:0]];
				pcNext <= pcPlusOne;
			end
		end
	end

endmodule

/* hdl/decode.sv */
`timescale 1ns/1ps

module decode
	import procPkg::*;
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic [dataWidth-1:0]   instruction,
	input  logic [dataWidth-1:0]   pcNext,
	input  logic                   stall,
	input  logic                   busStall,
	input  logic [regSelWidth-1:0] wbReg,
	input  logic [dataWidth-1:0]   wbData,
	input  logic                   wbWrite,
	output logic [dataWidth-1:0]   read1Data,
	output logic [dataWidth-1:0]   read2Data,
	output logic [dataWidth-1:0]   immExt,
	output aluOp_t                 aluOp,
	output logic                   useImm,
	output logic                   memRead,
	output logic                   memWrite,
	output logic                   regWrite,
	output logic [regSelWidth-1:0] writeReg,
	output logic [regSelWidth-1:0] rsSel,
	output logic [regSelWidth-1:0] rtSel,
	output logic                   halt,
	output logic                   branchTaken,
	output logic [dataWidth-1:0]   branchTarget
);

	logic [dataWidth-1:0]   regFile [regCount];
	opcode_t                opcode;
	logic [regSelWidth-1:0] rs, rt, rd, destId;
	logic [dataWidth-1:0]   rsValue, rtValue, immValue, offsetValue;
	aluOp_t                 aluOpId;
	logic                   useImmId, memReadId, memWriteId, regWriteId;
	logic                   usesRs, usesRt, destIsRt, isBeqz, isHalt;
	logic                   stopped;

	assign opcode = opcode_t'(instruction[opMsb:opLsb]);
	assign rs = instruction[rsMsb:rsLsb];
	assign rt = instruction[rtMsb:rtLsb];
	assign rd = instruction[rdMsb:rdLsb];
	assign immValue = {{(dataWidth-immMsb-1){instruction[immMsb]}}, instruction[immMsb:immLsb]};
	assign offsetValue = {{(dataWidth-offMsb-1){instruction[offMsb]}}, instruction[offMsb:offLsb]};

	always_ff @(posedge clk) begin
		if (wbWrite && wbReg != '0) begin
			regFile[wbReg] <= wbData;
		end
	end

	// r0 reads zero, a same-cycle write passes straight through
	assign rsValue = (rs == '0) ? '0 : (wbWrite && wbReg == rs) ? wbData : regFile[rs];
	assign rtValue = (rt == '0) ? '0 : (wbWrite && wbReg == rt) ? wbData : regFile[rt];

	always_comb begin
		aluOpId = aluAdd;
		{useImmId, memReadId, memWriteId, regWriteId} = 4'b0000;
		{usesRs, usesRt, destIsRt, isBeqz, isHalt} = 5'b00000;
		case (opcode)
			opAdd, opSub, opAnd, opXor: begin
				aluOpId = (opcode == opSub) ? aluSub : (opcode == opAnd) ? aluAnd :
					(opcode == opXor) ? aluXor : aluAdd;
				{regWriteId, usesRs, usesRt} = 3'b111;
			end
			opAddi: {useImmId, regWriteId, usesRs, destIsRt} = 4'b1111;
			opLd: {useImmId, memReadId, regWriteId, usesRs, destIsRt} = 5'b11111;
			opSt: {useImmId, memWriteId, usesRs, usesRt} = 4'b1111;
			opBeqz: {usesRs, isBeqz} = 2'b11;
			opHalt: isHalt = 1'b1;
			default: isHalt = 1'b0;
		endcase
	end

	assign destId = destIsRt ? rt : rd;

	// unused sources show as r0 so they never cause a hazard
	assign rsSel = (usesRs & ~stopped) ? rs : '0;
	assign rtSel = (usesRt & ~stopped) ? rt : '0;

	// branch resolved here against the register file value
	assign branchTarget = pcNext + offsetValue;
	assign branchTaken = isBeqz & (rsValue == '0) & ~stall & ~stopped;

	// ID/EX register
	always_ff @(posedge clk) begin
		if (rst) begin
			{memRead, memWrite, regWrite, halt} <= 4'b0000;
			stopped <= 1'b0;
		end else if (!busStall) begin
			if (stall | stopped) begin
				{memRead, memWrite, regWrite, halt} <= 4'b0000;
			end else begin
				{memRead, memWrite, regWrite, halt} <= {memReadId, memWriteId, regWriteId, isHalt};
				stopped <= isHalt;
			end
			read1Data <= rsValue;
			read2Data <= rtValue;
			immExt <= immValue;
			aluOp <= aluOpId;
			useImm <= useImmId;
			writeReg <= destId;
		end
	end

endmodule

/* hdl/hazardDetection.sv */
`timescale 1ns/1ps

module hazardDetection
	import procPkg::*;
(
	input  opcode_t                idOpcode,
	input  logic [regSelWidth-1:0] idRs,
	input  logic [regSelWidth-1:0] idRt,
	input  logic [regSelWidth-1:0] exWriteReg,
	input  logic                   exRegWrite,
	input  logic                   exMemRead,
	input  logic [regSelWidth-1:0] memWriteReg,
	input  logic                   memRegWrite,
	output logic                   stall,
	output logic                   fwdAFromEx,
	output logic                   fwdAFromMem,
	output logic                   fwdBFromEx,
	output logic                   fwdBFromMem
);

	logic rsInEx, rtInEx, rsInMem, rtInMem;
	logic loadUse, branchWait;

	// r0 is never a real dependency
	assign rsInEx = exRegWrite && exWriteReg != '0 && exWriteReg == idRs;
	assign rtInEx = exRegWrite && exWriteReg != '0 && exWriteReg == idRt;
	assign rsInMem = memRegWrite && memWriteReg != '0 && memWriteReg == idRs;
	assign rtInMem = memRegWrite && memWriteReg != '0 && memWriteReg == idRt;

	// load data is not ready until it leaves the bus
	assign loadUse = exMemRead & (rsInEx | rtInEx);

	// branch compares in decode, so wait for write-back
	assign branchWait = (idOpcode == opBeqz) & (rsInEx | rsInMem);

	assign stall = loadUse | branchWait;

	// selects for the instruction in ID, execute latches them with ID/EX
	assign fwdAFromEx = rsInEx;
	assign fwdAFromMem = rsInMem & ~rsInEx;
	assign fwdBFromEx = rtInEx;
	assign fwdBFromMem = rtInMem & ~rtInEx;

endmodule

/* hdl/execute.sv */
`timescale 1ns/1ps

module execute
	import procPkg::*;
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   busStall,
	input  logic [dataWidth-1:0]   read1Data,
	input  logic [dataWidth-1:0]   read2Data,
	input  logic [dataWidth-1:0]   immExt,
	input  aluOp_t                 aluOp,
	input  logic                   useImm,
	input  logic                   memRead,
	input  logic                   memWrite,
	input  logic                   regWrite,
	input  logic [regSelWidth-1:0] writeReg,
	input  logic                   halt,
	input  logic                   fwdAFromEx,
	input  logic                   fwdAFromMem,
	input  logic                   fwdBFromEx,
	input  logic                   fwdBFromMem,
	input  logic [dataWidth-1:0]   exMemResult,
	input  logic [dataWidth-1:0]   memWbResult,
	output logic [dataWidth-1:0]   aluResult,
	output logic [dataWidth-1:0]   storeData,
	output logic                   exMemRead,
	output logic                   exMemWrite,
	output logic                   exMemRegWrite,
	output logic [regSelWidth-1:0] exMemWriteReg,
	output logic                   exMemHalt
);

	logic                 selAEx, selAMem, selBEx, selBMem;
	logic [dataWidth-1:0] opA, opB, aluIn2, aluOut;

	// forwarding selects travel alongside ID/EX
	always_ff @(posedge clk) begin
		if (rst) begin
			{selAEx, selAMem, selBEx, selBMem} <= 4'b0000;
		end else if (!busStall) begin
			{selAEx, selAMem, selBEx, selBMem} <= {fwdAFromEx, fwdAFromMem, fwdBFromEx, fwdBFromMem};
		end
	end

	// EX path wins over MEM path
	assign opA = selAEx ? exMemResult : selAMem ? memWbResult : read1Data;
	assign opB = selBEx ? exMemResult : selBMem ? memWbResult : read2Data;
	assign aluIn2 = useImm ? immExt : opB;

	always_comb begin
		case (aluOp)
			aluSub: aluOut = opA - aluIn2;
			aluAnd: aluOut = opA & aluIn2;
			aluXor: aluOut = opA ^ aluIn2;
			default: aluOut = opA + aluIn2;
		endcase
	end

	// EX/MEM register
	always_ff @(posedge clk) begin
		if (rst) begin
			{exMemRead, exMemWrite, exMemRegWrite, exMemHalt} <= 4'b0000;
		end else if (!busStall) begin
			{exMemRead, exMemWrite, exMemRegWrite, exMemHalt} <= {memRead, memWrite, regWrite, halt};
			aluResult <= aluOut;
			storeData <= opB;
			exMemWriteReg <= writeReg;
		end
	end

endmodule

/* hdl/memory.sv */
`timescale 1ns/1ps

module memory
	import procPkg::*;
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic [dataWidth-1:0]   aluResult,
	input  logic [dataWidth-1:0]   storeData,
	input  logic                   memRead,
	input  logic                   memWrite,
	input  logic                   regWrite,
	input  logic [regSelWidth-1:0] writeReg,
	input  logic                   halt,
	input  logic [dataWidth-1:0]   wbDatRd,
	input  logic                   wbAck,
	output logic                   busStall,
	output logic                   wbCyc,
	output logic                   wbStb,
	output logic                   wbWe,
	output logic [dataWidth-1:0]   wbAdr,
	output logic [dataWidth-1:0]   wbDatWr,
	output logic [regSelWidth-1:0] wbReg,
	output logic [dataWidth-1:0]   wbData,
	output logic                   wbWrite,
	output logic                   halted
);

	memState_t state, stateNext;
	logic      haltWb;

	// freeze from the first cycle of an access until ack is sampled
	always_comb begin
		stateNext = state;
		busStall = 1'b0;
		case (state)
			memIdle: begin
				if (memRead | memWrite) begin
					stateNext = memAccess;
					busStall = 1'b1;
				end
			end
			memAccess: begin
				if (wbAck) begin
					stateNext = memIdle;
				end else begin
					busStall = 1'b1;
				end
			end
			default: stateNext = memIdle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= memIdle;
		end else begin
			state <= stateNext;
		end
	end

	// EX/MEM is frozen during the access so address and data hold still
	assign wbCyc = (state == memAccess);
	assign wbStb = wbCyc;
	assign wbWe = wbCyc & memWrite;
	assign wbAdr = aluResult;
	assign wbDatWr = storeData;

	// MEM/WB register
	always_ff @(posedge clk) begin
		if (rst) begin
			wbWrite <= 1'b0;
			haltWb <= 1'b0;
			halted <= 1'b0;
		end else begin
			if (!busStall) begin
				wbWrite <= regWrite;
				haltWb <= halt;
				wbReg <= writeReg;
				wbData <= memRead ? wbDatRd : aluResult;
			end
			if (haltWb) begin
				halted <= 1'b1;
			end
		end
	end

endmodule

/* hdl/proc.sv */
`timescale 1ns/1ps

module proc
	import procPkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	output logic                 wbCyc,
	output logic                 wbStb,
	output logic                 wbWe,
	output logic [dataWidth-1:0] wbAdr,
	output logic [dataWidth-1:0] wbDatWr,
	input  logic [dataWidth-1:0] wbDatRd,
	input  logic                 wbAck,
	output logic                 halted
);

	// IF/ID
	logic [dataWidth-1:0]   instructionId, pcNextId;
	logic                   branchTakenId;
	logic [dataWidth-1:0]   branchTargetId;
	logic [regSelWidth-1:0] rsSelId, rtSelId;

	// ID/EX
	logic [dataWidth-1:0]   read1DataEx, read2DataEx, immExtEx;
	aluOp_t                 aluOpEx;
	logic                   useImmEx, memReadEx, memWriteEx, regWriteEx, haltEx;
	logic [regSelWidth-1:0] writeRegEx;

	// EX/MEM
	logic [dataWidth-1:0]   aluResultMem, storeDataMem;
	logic                   memReadMem, memWriteMem, regWriteMem, haltMem;
	logic [regSelWidth-1:0] writeRegMem;

	// MEM/WB
	logic [regSelWidth-1:0] wbRegWb;
	logic [dataWidth-1:0]   wbDataWb;
	logic                   wbWriteWb;

	logic stall, busStall;
	logic fwdAFromEx, fwdAFromMem, fwdBFromEx, fwdBFromMem;

	fetch i_fetch (
		.clk(clk), .rst(rst), .stall(stall), .busStall(busStall), .halt(haltEx),
		.branchTaken(branchTakenId), .branchTarget(branchTargetId),
		.instruction(instructionId), .pcNext(pcNextId)
	);

	decode i_decode (
		.clk(clk), .rst(rst), .instruction(instructionId), .pcNext(pcNextId),
		.stall(stall), .busStall(busStall),
		.wbReg(wbRegWb), .wbData(wbDataWb), .wbWrite(wbWriteWb),
		.read1Data(read1DataEx), .read2Data(read2DataEx), .immExt(immExtEx),
		.aluOp(aluOpEx), .useImm(useImmEx), .memRead(memReadEx), .memWrite(memWriteEx),
		.regWrite(regWriteEx), .writeReg(writeRegEx), .rsSel(rsSelId), .rtSel(rtSelId),
		.halt(haltEx), .branchTaken(branchTakenId), .branchTarget(branchTargetId)
	);

	hazardDetection i_hazardDetection (
		.idOpcode(opcode_t'(instructionId[opMsb:opLsb])), .idRs(rsSelId), .idRt(rtSelId),
		.exWriteReg(writeRegEx), .exRegWrite(regWriteEx), .exMemRead(memReadEx),
		.memWriteReg(writeRegMem), .memRegWrite(regWriteMem),
		.stall(stall), .fwdAFromEx(fwdAFromEx), .fwdAFromMem(fwdAFromMem),
		.fwdBFromEx(fwdBFromEx), .fwdBFromMem(fwdBFromMem)
	);

	execute i_execute (
		.clk(clk), .rst(rst), .busStall(busStall),
		.read1Data(read1DataEx), .read2Data(read2DataEx), .immExt(immExtEx),
		.aluOp(aluOpEx), .useImm(useImmEx), .memRead(memReadEx), .memWrite(memWriteEx),
		.regWrite(regWriteEx), .writeReg(writeRegEx), .halt(haltEx),
		.fwdAFromEx(fwdAFromEx), .fwdAFromMem(fwdAFromMem),
		.fwdBFromEx(fwdBFromEx), .fwdBFromMem(fwdBFromMem),
		.exMemResult(aluResultMem), .memWbResult(wbDataWb),
		.aluResult(aluResultMem), .storeData(storeDataMem),
		.exMemRead(memReadMem), .exMemWrite(memWriteMem), .exMemRegWrite(regWriteMem),
		.exMemWriteReg(writeRegMem), .exMemHalt(haltMem)
	);

	memory i_memory (
		.clk(clk), .rst(rst), .aluResult(aluResultMem), .storeData(storeDataMem),
		.memRead(memReadMem), .memWrite(memWriteMem), .regWrite(regWriteMem),
		.writeReg(writeRegMem), .halt(haltMem), .wbDatRd(wbDatRd), .wbAck(wbAck),
		.busStall(busStall), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
		.wbAdr(wbAdr), .wbDatWr(wbDatWr),
		.wbReg(wbRegWb), .wbData(wbDataWb), .wbWrite(wbWriteWb), .halted(halted)
	);

endmodule

/* verif/proc_asserts.sv */
`timescale 1ns/1ps

module procAsserts
	import procPkg::*;
(
	input logic                 clk,
	input logic                 rst,
	input logic                 wbCyc,
	input logic                 wbStb,
	input logic                 wbWe,
	input logic [dataWidth-1:0] wbAdr,
	input logic [dataWidth-1:0] wbDatWr,
	input logic                 wbAck,
	input logic                 halted
);

	// stores the program makes, in order
	logic [dataWidth-1:0] expAdr [4] = '{16'h0000, 16'h0001, 16'h0002, 16'h0004};
	logic [dataWidth-1:0] expDat [4] = '{16'h0008, 16'h0003, 16'h1237, 16'h0005};

	int         storeCount;
	int         errorCount = 0;
	logic       storeAck;
	logic [1:0] idx;

	assign storeAck = wbCyc & wbStb & wbWe & wbAck;
	assign idx = storeCount[1:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			storeCount <= 0;
		end else if (storeAck) begin
			storeCount <= storeCount + 1;
		end
	end

	// outputs quiet one cycle after reset is seen
	resetQuiet: assert property (@(posedge clk) $past(rst) |-> !wbCyc && !wbStb && !halted)
		else begin
			errorCount++;
			$error("bus or halted active during reset at %0t", $time);
		end

	stbNeedsCyc: assert property (@(posedge clk) disable iff (rst) wbStb |-> wbCyc)
		else begin
			errorCount++;
			$error("stb high without cyc at %0t", $time);
		end

	// master holds the request until ack
	requestHold: assert property (@(posedge clk) disable iff (rst)
		$past(wbStb && !wbAck) |-> wbStb && wbAdr == $past(wbAdr) && wbWe == $past(wbWe)
			&& wbDatWr == $past(wbDatWr))
		else begin
			errorCount++;
			$error("request changed before ack at %0t", $time);
		end

	dropAfterAck: assert property (@(posedge clk) disable iff (rst) $past(wbStb && wbAck) |-> !wbStb)
		else begin
			errorCount++;
			$error("stb still high the cycle after ack at %0t", $time);
		end

	storeLimit: assert property (@(posedge clk) disable iff (rst) storeAck |-> storeCount < 4)
		else begin
			errorCount++;
			$error("extra store to %h at %0t", wbAdr, $time);
		end

	storeAdr: assert property (@(posedge clk) disable iff (rst)
		storeAck && storeCount < 4 |-> wbAdr == expAdr[idx])
		else begin
			errorCount++;
			$error("Error at %0t: wbAdr expected %h, got %h", $time, expAdr[idx], wbAdr);
		end

	storeDat: assert property (@(posedge clk) disable iff (rst)
		storeAck && storeCount < 4 |-> wbDatWr == expDat[idx])
		else begin
			errorCount++;
			$error("Error at %0t: wbDatWr expected %h, got %h", $time, expDat[idx], wbDatWr);
		end

	haltAfterStores: assert property (@(posedge clk) disable iff (rst)
		$rose(halted) |-> storeCount == 4)
		else begin
			errorCount++;
			$error("Error at %0t: storeCount expected 4, got %0d", $time, storeCount);
		end

	haltSticky: assert property (@(posedge clk) disable iff (rst) $past(halted) |-> halted)
		else begin
			errorCount++;
			$error("halted dropped at %0t", $time);
		end

	quietAfterHalt: assert property (@(posedge clk) disable iff (rst) halted |-> !wbCyc)
		else begin
			errorCount++;
			$error("bus cycle started after halt at %0t", $time);
		end

endmodule

/* verif/procTb.sv */
`timescale 1ns/1ps

module procTb
	import procPkg::*;
();

	localparam int clkPeriod = 20;
	localparam int resetCycles = 4;
	localparam int slaveWords = 32;
	localparam int maxWait = 3;
	localparam int haltTimeout = 500;
	localparam int settleCycles = 10;
	localparam logic [31:0] seed = 32'hde01;

	logic                 clk = 1'b0;
	logic                 rst;
	logic                 wbCyc;
	logic                 wbStb;
	logic                 wbWe;
	logic [dataWidth-1:0] wbAdr;
	logic [dataWidth-1:0] wbDatWr;
	logic [dataWidth-1:0] wbDatRd;
	logic                 wbAck;
	logic                 halted;

	logic [dataWidth-1:0] slaveMem [slaveWords];
	logic [dataWidth-1:0] storeLogAdr [$];
	logic [dataWidth-1:0] storeLogDat [$];
	int                   waitLeft;
	bit                   busy;

	proc i_dut (
		.clk(clk), .rst(rst),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
		.wbDatWr(wbDatWr), .wbDatRd(wbDatRd), .wbAck(wbAck),
		.halted(halted)
	);

	bind proc procAsserts i_asserts (
		.clk(clk), .rst(rst), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
		.wbAdr(wbAdr), .wbDatWr(wbDatWr), .wbAck(wbAck), .halted(halted)
	);

	always #(clkPeriod / 2) clk = ~clk;

	// word address wraps onto 32 words, so 16'hfff0 lands on word 16
	task automatic respondToAccess();
		if (wbWe) begin
			slaveMem[wbAdr[4:0]] = wbDatWr;
			storeLogAdr.push_back(wbAdr);
			storeLogDat.push_back(wbDatWr);
		end
		wbDatRd = slaveMem[wbAdr[4:0]];
		wbAck = 1'b1;
	endtask

	// Wishbone slave, ack held for one cycle after a random wait
	always @(negedge clk) begin
		if (rst) begin
			wbAck = 1'b0;
			busy = 1'b0;
		end else if (wbAck) begin
			wbAck = 1'b0;
		end else if (wbCyc && wbStb) begin
			if (!busy) begin
				busy = 1'b1;
				waitLeft = int'($urandom % (maxWait + 1));
			end
			if (waitLeft == 0) begin
				respondToAccess();
				busy = 1'b0;
			end else begin
				waitLeft--;
			end
		end
	end

	initial begin : mainFlow
		int cycles;
		int settle;
		bit timedOut;
		rst = 1'b1;
		wbAck = 1'b0;
		wbDatRd = '0;
		busy = 1'b0;
		waitLeft = 0;
		timedOut = 1'b0;
		void'($urandom(seed));
		for (int i = 0; i < slaveWords; i++) begin
			slaveMem[i] = '0;
		end
		slaveMem[16] = 16'h1234;
		repeat (resetCycles) @(negedge clk);
		rst = 1'b0;

		// run until the program halts
		cycles = 0;
		while (!halted && i_dut.i_asserts.errorCount == 0 && !timedOut) begin
			@(negedge clk);
			cycles++;
			if (cycles >= haltTimeout) begin
				timedOut = 1'b1;
			end
		end

		// a few more cycles so halted and the idle bus are watched
		settle = 0;
		while (!timedOut && settle < settleCycles && i_dut.i_asserts.errorCount == 0) begin
			@(negedge clk);
			settle++;
		end

		if (!timedOut && halted && i_dut.i_asserts.errorCount == 0) begin
			foreach (storeLogAdr[i]) begin
				$display("store %0d: adr %h data %h", i, storeLogAdr[i], storeLogDat[i]);
			end
			$display("Result: PASSED");
			$finish;
		end else begin
			if (timedOut) begin
				$display("timed out after %0d cycles waiting for halted", cycles);
			end else begin
				$display("%0d assertion checks failed", i_dut.i_asserts.errorCount);
			end
			$display("Result: FAILED");
			$fatal(1, "simulation stopped on failure");
		end
	end

endmodule

/* all.f */
hdl/procPkg.sv
hdl/fetch.sv
hdl/decode.sv
hdl/hazardDetection.sv
hdl/execute.sv
hdl/memory.sv
hdl/proc.sv
verif/proc_asserts.sv
verif/procTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= procTb
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ps
RUN_ARGS ?= +verilator+error+limit+100
FAIL_MSG ?= Result: FAILED
PASS_MSG ?= Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a verdict"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* program.hex */
// one instruction word per line, word address 0 first
4025
4043
c14c
8060
cb30
8081
88b0
dd58
80c2
6002
8023
0800
6101
d63c
80e4
0000
